// ==== verilog/wb_consts.svh ====
`ifndef WB_CONSTS_SVH
`define WB_CONSTS_SVH

// ------------------------------------------------------------
// Datapath widths
// ------------------------------------------------------------

`define WB_XLEN             32              // Register and PC width
`define WB_REG_AW           5               // GPR address bits

// Stage PC value out of reset
`define WB_PC_RESET         32'h8000_0000

// ------------------------------------------------------------
// Trap cause codes, mcause encoding
// ------------------------------------------------------------

`define WB_TRAP_BREAKPT     6'd3            // EBREAK
`define WB_TRAP_LDACCESS    6'd5            // Load bus error
`define WB_TRAP_STACCESS    6'd7            // Store bus error
`define WB_TRAP_ECALLM      6'd11           // ECALL from M mode

`endif

// ==== verilog/wb_pkg.sv ====
`include "wb_consts.svh"

package wb_pkg;

    // Functional unit which produced the instruction result
    typedef enum logic [2:0] {
        FU_NONE = 3'd0,
        FU_ALU  = 3'd1,
        FU_MUL  = 3'd2,
        FU_ASI  = 3'd3,
        FU_CSR  = 3'd4,
        FU_CFU  = 3'd5,
        FU_LSU  = 3'd6
    } fu_t;

    // Control flow micro-ops
    typedef enum logic [4:0] {
        CFU_TAKEN     = 5'd0,
        CFU_NOT_TAKEN = 5'd1,
        CFU_JALI      = 5'd2,
        CFU_JALR      = 5'd3,
        CFU_EBREAK    = 5'd4,
        CFU_ECALL     = 5'd5,
        CFU_MRET      = 5'd6
    } cfu_op_t;

    typedef enum logic [1:0] {
        LSU_BYTE = 2'b01,
        LSU_HALF = 2'b10,
        LSU_WORD = 2'b11
    } lsu_size_t;

    // Views of the 5-bit uop field
    typedef struct packed {
        logic read;
        logic write;
        logic set;
        logic clr;
    } csr_uop_t;                            // Sits in uop[3:0]

    typedef struct packed {
        logic      load;
        logic      store;
        lsu_size_t size;
        logic      is_signed;
    } lsu_uop_t;

    // ------------------------------------------------------------
    // Bundles between stage and core
    // ------------------------------------------------------------

    typedef struct packed {
        logic [`WB_REG_AW-1:0] rd;
        logic [`WB_XLEN-1:0]   opr_a;       // Finished result for ALU, MUL, ASI
        logic [`WB_XLEN-1:0]   opr_b;       // CSR address or load address
        fu_t                   fu;
        logic [4:0]            uop;
        logic                  trap;        // Trap raised by an earlier stage
        logic [1:0]            size;        // Instr size in halfwords
        logic [31:0]           instr;
    } s4_op_t;

    typedef struct packed {
        logic                en;
        logic                wr;
        logic                set;
        logic                clr;
        logic [11:0]         addr;
        logic [`WB_XLEN-1:0] wdata;
    } csr_bus_t;

    typedef struct packed {
        logic                  wen;
        logic [`WB_REG_AW-1:0] rd;
        logic [`WB_XLEN-1:0]   wdata;
    } gpr_wb_t;

    typedef struct packed {
        logic                valid;
        logic [`WB_XLEN-1:0] pc;
        logic [31:0]         instr;
    } trace_t;

endpackage

// ==== verilog/wb_pc_track.sv ====
`timescale 1ns/100ps
`include "wb_consts.svh"

module wb_pc_track (
    input  logic                g_clk,
    input  logic                g_resetn,
    input  logic                progress,       // Stage retires this cycle
    input  logic                cf_done,        // Control flow acknowledged
    input  logic [`WB_XLEN-1:0] cf_target,
    input  logic [1:0]          size,           // In halfwords
    output logic [`WB_XLEN-1:0] pc,
    output logic [`WB_XLEN-1:0] next_pc         // Sequential successor
);

    logic [`WB_XLEN-1:0] pc_q;

    // Halfword count to bytes
    assign next_pc = pc_q + {{(`WB_XLEN-3){1'b0}}, size, 1'b0};
    assign pc      = pc_q;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc_q <= `WB_PC_RESET;
        end else if (cf_done) begin
            pc_q <= cf_target;                  // Redirect wins
        end else if (progress) begin
            pc_q <= next_pc;
        end
    end

endmodule

// ==== verilog/wb_csr_access.sv ====
`timescale 1ns/100ps

module wb_csr_access (
    input  logic              g_clk,
    input  logic              g_resetn,
    input  logic              progress,
    input  wb_pkg::s4_op_t    op,
    output wb_pkg::csr_bus_t  csr,
    output logic              rd_wen        // Write read data to rd
);

    import wb_pkg::*;

    logic     fu_csr;
    logic     done_q;                       // Access already issued
    csr_uop_t cu;

    assign fu_csr = (op.fu == FU_CSR);
    assign cu     = csr_uop_t'(op.uop[3:0]);

    // One access per instruction, first cycle only
    assign csr.en    = fu_csr && !done_q;
    assign csr.wr    = fu_csr && cu.write;
    assign csr.set   = fu_csr && cu.set;
    assign csr.clr   = fu_csr && cu.clr;
    assign csr.addr  = op.opr_b[11:0];
    assign csr.wdata = op.opr_a;

    // Read data only valid alongside en
    assign rd_wen = fu_csr && cu.read && !done_q;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            done_q <= 1'b0;
        end else begin
            done_q <= !progress && (done_q || csr.en);
        end
    end

endmodule

// ==== verilog/wb_cfu.sv ====
`timescale 1ns/100ps
`include "wb_consts.svh"

module wb_cfu (
    input  logic                g_clk,
    input  logic                g_resetn,
    input  logic                progress,
    input  wb_pkg::s4_op_t      op,
    input  logic                lsu_trap,       // Memory bus error
    input  logic                lsu_store,      // Errored access was a store
    input  logic [`WB_XLEN-1:0] csr_mepc,
    input  logic [`WB_XLEN-1:0] csr_mtvec,
    input  logic                cf_ack,
    output logic                cf_req,
    output logic [`WB_XLEN-1:0] cf_target,
    output logic                cf_done,        // Request acknowledged now
    output logic                cfu_busy,
    output logic                link_wen,
    output logic                trap_cpu,
    output logic [5:0]          trap_cause,
    output logic                exec_mret
);

    import wb_pkg::*;

    cfu_op_t cop;
    logic    fu_cfu;
    logic    cf_taken;                      // Branch or jump
    logic    cf_ebreak;
    logic    cf_ecall;
    logic    cf_mret;
    logic    cf_trap;                       // Anything heading to MTVEC
    logic    done_q;

    // ------------------------------------------------------------
    // Opcode decode
    // ------------------------------------------------------------

    assign fu_cfu    = (op.fu == FU_CFU);
    assign cop       = cfu_op_t'(op.uop);
    assign cf_taken  = fu_cfu && (cop == CFU_TAKEN || cop == CFU_JALI ||
                                  cop == CFU_JALR);
    assign cf_ebreak = fu_cfu && (cop == CFU_EBREAK);
    assign cf_ecall  = fu_cfu && (cop == CFU_ECALL);
    assign cf_mret   = fu_cfu && (cop == CFU_MRET);
    assign link_wen  = fu_cfu && (cop == CFU_JALI || cop == CFU_JALR);

    assign trap_cpu  = cf_ebreak || cf_ecall || op.trap || lsu_trap;
    assign cf_trap   = trap_cpu;

    // ------------------------------------------------------------
    // Request and target
    // ------------------------------------------------------------

    // Held until acknowledged, then quiet until progress
    assign cf_req  = (cf_taken || cf_mret || cf_trap) && !done_q;
    assign cf_done = cf_req && cf_ack;

    assign cfu_busy = cf_req && !cf_ack;

    always_comb begin
        if (cf_trap) begin
            cf_target = csr_mtvec;
        end else if (cf_mret) begin
            cf_target = csr_mepc;
        end else begin
            cf_target = op.opr_a;           // Computed jump/branch target
        end
    end

    // Load error first, opr_a carries causes from earlier stages
    always_comb begin
        if (lsu_trap && !lsu_store) begin
            trap_cause = `WB_TRAP_LDACCESS;
        end else if (lsu_trap) begin
            trap_cause = `WB_TRAP_STACCESS;
        end else if (cf_ebreak) begin
            trap_cause = `WB_TRAP_BREAKPT;
        end else if (cf_ecall) begin
            trap_cause = `WB_TRAP_ECALLM;
        end else begin
            trap_cause = op.opr_a[5:0];
        end
    end

    assign exec_mret = cf_mret && progress;     // Tells CSRs to restore

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            done_q <= 1'b0;
        end else begin
            done_q <= !progress && (done_q || cf_done);
        end
    end

endmodule

// ==== verilog/wb_lsu_resp.sv ====
`timescale 1ns/100ps

module wb_lsu_resp (
    input  logic           g_clk,
    input  logic           g_resetn,
    input  logic           progress,
    input  wb_pkg::s4_op_t op,
    input  logic           dmem_recv,
    input  logic           dmem_error,
    output logic           dmem_ack,
    output logic           lsu_busy,
    output logic           lsu_trap,        // Bus error on our response
    output logic           lsu_store,
    output logic           load_wen
);

    import wb_pkg::*;

    lsu_uop_t lu;
    logic     fu_lsu;
    logic     rsp_take;                     // Response accepted this cycle
    logic     seen_q;                       // Response already taken
    logic     err_q;                        // Taken response had an error

    assign fu_lsu    = (op.fu == FU_LSU);
    assign lu        = lsu_uop_t'(op.uop);
    assign lsu_store = fu_lsu && lu.store;

    // Only accept while a response is still owed
    assign dmem_ack = fu_lsu && !seen_q;
    assign rsp_take = dmem_recv && dmem_ack;

    assign lsu_busy = fu_lsu && !(seen_q || rsp_take);

    // Error stays up so the trap request holds
    assign lsu_trap = (rsp_take && dmem_error) || err_q;

    assign load_wen = rsp_take && !dmem_error && lu.load;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            seen_q <= 1'b0;
            err_q  <= 1'b0;
        end else begin
            seen_q <= !progress && (seen_q || rsp_take);
            err_q  <= !progress && (err_q || (rsp_take && dmem_error));
        end
    end

endmodule

// ==== verilog/wb_load_align.sv ====
`timescale 1ns/100ps
`include "wb_consts.svh"

module wb_load_align (
    input  logic                  [`WB_XLEN-1:0] rdata,
    input  logic                  [1:0]          addr_lo,   // Byte offset
    input  wb_pkg::lsu_size_t                    size,
    input  logic                                 is_signed,
    input  logic                                 strb0,     // Byte lane 0 used
    output logic                  [`WB_XLEN-1:0] data
);

    import wb_pkg::*;

    logic       is_byte;
    logic       is_half;
    logic       is_word;
    logic [7:0] b0;
    logic [7:0] b1;
    logic [15:0] h1;

    assign is_byte = (size == LSU_BYTE);
    assign is_half = (size == LSU_HALF);
    assign is_word = (size == LSU_WORD);

    // ------------------------------------------------------------
    // Lane steering
    // ------------------------------------------------------------

    assign b0 = {8{strb0}}                           & rdata[7:0]   |
                {8{is_byte && addr_lo == 2'b01}}     & rdata[15:8]  |
                {8{is_byte && addr_lo == 2'b10}}     & rdata[23:16] |
                {8{is_half && addr_lo[1]}}           & rdata[23:16] |
                {8{is_byte && addr_lo == 2'b11}}     & rdata[31:24];

    assign b1 = {8{is_byte && is_signed}}            & {8{b0[7]}}   |
                {8{is_half && !addr_lo[1]}}          & rdata[15:8]  |
                {8{is_half && addr_lo[1]}}           & rdata[31:24] |
                {8{is_word}}                         & rdata[15:8];

    // Upper half, sign from b1 covers both byte and half
    assign h1 = {16{(is_byte || is_half) && is_signed}} & {16{b1[7]}} |
                {16{is_word}}                           & rdata[31:16];

    assign data = {h1, b1, b0};

endmodule

// ==== verilog/frv_writeback.sv ====
`timescale 1ns/100ps
`include "wb_consts.svh"

module frv_writeback (
    input  logic                g_clk,
    input  logic                g_resetn,
    input  wb_pkg::s4_op_t      s4_op,
    input  logic                s4_valid,
    output logic                s4_busy,
    output wb_pkg::gpr_wb_t     gpr_wb,
    output logic                fwd_load,
    output logic                fwd_csr,
    output wb_pkg::csr_bus_t    csr,
    input  logic [`WB_XLEN-1:0] csr_rdata,
    input  logic [`WB_XLEN-1:0] csr_mepc,
    input  logic [`WB_XLEN-1:0] csr_mtvec,
    output logic                cf_req,
    output logic [`WB_XLEN-1:0] cf_target,
    input  logic                cf_ack,
    output logic                trap_cpu,
    output logic [5:0]          trap_cause,
    output logic [`WB_XLEN-1:0] trap_pc,
    output logic                exec_mret,
    input  logic                dmem_recv,
    input  logic                dmem_error,
    input  logic [`WB_XLEN-1:0] dmem_rdata,
    output logic                dmem_ack,
    output wb_pkg::trace_t      trace
);

    import wb_pkg::*;

    s4_op_t              op;                // Valid-gated instruction
    lsu_uop_t            lu;
    logic                progress;
    logic                cfu_busy;
    logic                lsu_busy;
    logic                cf_done;
    logic                lsu_trap;
    logic                lsu_store;
    logic                csr_rd_wen;
    logic                load_wen;
    logic                link_wen;
    logic                pass_wen;          // ALU, MUL, ASI result in opr_a
    logic [`WB_XLEN-1:0] pc;
    logic [`WB_XLEN-1:0] next_pc;
    logic [`WB_XLEN-1:0] load_data;
    logic [`WB_XLEN-1:0] wb_wdata;          // Selected GPR write data

    // ------------------------------------------------------------
    // Valid gating and stall
    // ------------------------------------------------------------

    always_comb begin
        op = s4_op;
        if (!s4_valid) begin
            op.fu   = FU_NONE;
            op.trap = 1'b0;                 // Bubble raises nothing
        end
    end

    assign lu       = lsu_uop_t'(op.uop);
    assign s4_busy  = cfu_busy || lsu_busy;
    assign progress = s4_valid && !s4_busy;

    wb_pc_track u_pc (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .progress  (progress),
        .cf_done   (cf_done),
        .cf_target (cf_target),
        .size      (op.size),
        .pc        (pc),
        .next_pc   (next_pc)
    );

    wb_csr_access u_csr (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .progress (progress),
        .op       (op),
        .csr      (csr),
        .rd_wen   (csr_rd_wen)
    );

    wb_cfu u_cfu (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .progress   (progress),
        .op         (op),
        .lsu_trap   (lsu_trap),
        .lsu_store  (lsu_store),
        .csr_mepc   (csr_mepc),
        .csr_mtvec  (csr_mtvec),
        .cf_ack     (cf_ack),
        .cf_req     (cf_req),
        .cf_target  (cf_target),
        .cf_done    (cf_done),
        .cfu_busy   (cfu_busy),
        .link_wen   (link_wen),
        .trap_cpu   (trap_cpu),
        .trap_cause (trap_cause),
        .exec_mret  (exec_mret)
    );

    wb_lsu_resp u_lsu (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .progress   (progress),
        .op         (op),
        .dmem_recv  (dmem_recv),
        .dmem_error (dmem_error),
        .dmem_ack   (dmem_ack),
        .lsu_busy   (lsu_busy),
        .lsu_trap   (lsu_trap),
        .lsu_store  (lsu_store),
        .load_wen   (load_wen)
    );

    wb_load_align u_align (
        .rdata     (dmem_rdata),
        .addr_lo   (op.opr_b[1:0]),
        .size      (lu.size),
        .is_signed (lu.is_signed),
        .strb0     (op.opr_a[0]),           // Strobes from memory stage
        .data      (load_data)
    );

    // ------------------------------------------------------------
    // GPR writeback and forwarding
    // ------------------------------------------------------------

    assign pass_wen = (op.fu == FU_ALU) || (op.fu == FU_MUL) || (op.fu == FU_ASI);

    assign gpr_wb.wen = !op.trap &&
                        (pass_wen || csr_rd_wen || load_wen || link_wen);
    assign gpr_wb.rd  = op.rd;

    always_comb begin
        case (op.fu)
            FU_CSR:  wb_wdata = csr_rdata;
            FU_LSU:  wb_wdata = load_data;
            FU_CFU:  wb_wdata = next_pc;    // Link address
            default: wb_wdata = op.opr_a;
        endcase
    end

    assign gpr_wb.wdata = wb_wdata;

    assign fwd_load = (op.fu == FU_LSU) && lu.load;
    assign fwd_csr  = (op.fu == FU_CSR);

    assign trap_pc = pc;

    // Trace once per instruction, at retire or first ack
    assign trace.valid = |op.size && (progress || cf_done);
    assign trace.pc    = pc;
    assign trace.instr = op.instr;

endmodule

// ==== testbench/tb_writeback.sv ====
`timescale 1ns/100ps
`include "wb_consts.svh"

module tb_writeback;

    import wb_pkg::*;

    localparam int WAIT_LIMIT = 40;         // Cycles before a wait gives up

    logic                g_clk;
    logic                g_resetn;
    s4_op_t              s4_op;
    logic                s4_valid;
    logic                s4_busy;
    gpr_wb_t             gpr_wb;
    logic                fwd_load;
    logic                fwd_csr;
    csr_bus_t            csr;
    logic [`WB_XLEN-1:0] csr_rdata;
    logic [`WB_XLEN-1:0] csr_mepc;
    logic [`WB_XLEN-1:0] csr_mtvec;
    logic                cf_req;
    logic [`WB_XLEN-1:0] cf_target;
    logic                cf_ack;
    logic                trap_cpu;
    logic [5:0]          trap_cause;
    logic [`WB_XLEN-1:0] trap_pc;
    logic                exec_mret;
    logic                dmem_recv;
    logic                dmem_error;
    logic [`WB_XLEN-1:0] dmem_rdata;
    logic                dmem_ack;
    trace_t              trace;

    // Run state and expectations for the op in flight
    int                  errors;
    int                  tests;
    int                  last_cycles;       // Negedges until progress
    logic [15:0]         lfsr;
    string               test_name;
    logic [31:0]         pc_model;          // Reference stage PC
    logic                exp_wen;
    logic [31:0]         exp_wdata;
    logic                exp_redirect;
    logic [31:0]         exp_target;
    logic                exp_trap;
    logic [5:0]          exp_cause;
    logic                exp_mret;
    logic                exp_csr_chk;
    csr_bus_t            exp_csr;
    logic [1:0]          exp_fwd;           // fwd_load, fwd_csr
    int                  resp_delay;        // Negative means no memory response
    logic                resp_err;
    logic [31:0]         resp_data;

    frv_writeback UUT (.*);

    always #10 g_clk = ~g_clk;

    // ------------------------------------------------------------
    // Reference models and random source
    // ------------------------------------------------------------

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};      // One step per bit
        end
        return r;
    endfunction

    function automatic logic [31:0] load_ref(input logic [31:0] rdata, input logic [1:0] addr,
                                             input lsu_size_t size, input logic sgn);
        logic [31:0] sh;
        sh = rdata >> (8 * addr);           // Addressed lane down to bit 0
        case (size)
            LSU_BYTE: return sgn ? {{24{sh[7]}}, sh[7:0]} : {24'h0, sh[7:0]};
            LSU_HALF: return sgn ? {{16{sh[15]}}, sh[15:0]} : {16'h0, sh[15:0]};
            default:  return rdata;
        endcase
    endfunction

    function automatic logic [31:0] next_pc_ref(input logic [31:0] pc, input logic [1:0] size);
        return pc + {29'h0, size, 1'b0};    // Halfwords to bytes
    endfunction

    function automatic s4_op_t make_op(input fu_t fu, input logic [4:0] uop,
                                       input logic [31:0] a, input logic [31:0] b,
                                       input logic trap);
        s4_op_t      o;
        logic [31:0] r;
        r       = rand_bits(6);
        o.rd    = r[4:0];
        o.size  = r[5] ? 2'd2 : 2'd1;       // Compressed or full width
        o.opr_a = a;
        o.opr_b = b;
        o.fu    = fu;
        o.uop   = uop;
        o.trap  = trap;
        o.instr = rand_bits(32);
        return o;
    endfunction

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------

    task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s expected %0h actual %0h", what, exp, act);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $finish;
    endtask

    task automatic check_idle(input string name);
        check_val({name, " idle outputs"}, 0,
                  {gpr_wb.wen, cf_req, csr.en, dmem_ack, trace.valid, exec_mret});
    endtask

    task automatic check_redirect(input string name);
        check_val({name, " cf_req"}, 1, cf_req);
        check_val({name, " busy"}, 1, s4_busy);        // No ack yet
        check_val({name, " cf_target"}, exp_target, cf_target);
        check_val({name, " trap_cpu"}, exp_trap, trap_cpu);
        check_val({name, " exec_mret"}, 0, exec_mret);  // Pulses only at retire
        if (exp_trap) begin
            check_val({name, " trap_cause"}, exp_cause, trap_cause);
            check_val({name, " trap_pc"}, pc_model, trap_pc);
        end
    endtask

    // Retire-cycle compare against the expectations
    always @(negedge g_clk) begin
        if (g_resetn && s4_valid && !s4_busy) begin
            check_val({test_name, " gpr wen"}, exp_wen, gpr_wb.wen);
            if (exp_wen) begin
                check_val({test_name, " gpr rd"}, s4_op.rd, gpr_wb.rd);
                check_val({test_name, " gpr wdata"}, exp_wdata, gpr_wb.wdata);
            end
            check_val({test_name, " fwd"}, exp_fwd, {fwd_load, fwd_csr});
            check_val({test_name, " cf_req"}, exp_redirect, cf_req);
            check_val({test_name, " exec_mret"}, exp_mret, exec_mret);
            check_val({test_name, " trace valid"}, 1, trace.valid);
            check_val({test_name, " trace pc"}, pc_model, trace.pc);
            check_val({test_name, " trace instr"}, s4_op.instr, trace.instr);
            if (exp_csr_chk)
                check_val({test_name, " csr bus"}, exp_csr, csr);
            pc_model = exp_redirect ? exp_target : next_pc_ref(pc_model, s4_op.size);
        end
    end

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------

    task automatic clear_exp();
        exp_wen      = 1'b0;
        exp_wdata    = '0;
        exp_redirect = 1'b0;
        exp_target   = '0;
        exp_trap     = 1'b0;
        exp_cause    = '0;
        exp_mret     = 1'b0;
        exp_csr_chk  = 1'b0;
        exp_csr      = '0;
        exp_fwd      = '0;
        resp_delay   = -1;
        resp_err     = 1'b0;
        resp_data    = '0;
    endtask

    task automatic wait_not_busy(input string name);
        int n;
        n = 0;
        do begin
            @(negedge g_clk);
            n++;
        end while (s4_busy && n < WAIT_LIMIT);
        if (s4_busy)
            abort_run({"Timeout: stage stayed busy in ", name});
        last_cycles = n;
    endtask

    task automatic wait_cf_req(input string name);
        int n;
        n = 0;
        do begin
            @(negedge g_clk);
            n++;
        end while (!cf_req && n < WAIT_LIMIT);
        if (!cf_req)
            abort_run({"Timeout: no control flow request in ", name});
    endtask

    task automatic finish_test(input string name, input int err_start);
        tests++;
        if (errors == err_start)
            $display("test %-14s ok", name);
        else
            $display("test %-14s FAILED, %0d errors", name, errors - err_start);
    endtask

    // One op through the stage; called 2 ns after a rising edge
    task automatic run_op(input string name, input s4_op_t o);
        int err_start;
        err_start = errors;
        test_name = name;
        s4_op     = o;
        s4_valid  = 1'b1;
        if (resp_delay >= 0) begin
            for (int n = 0; n < resp_delay; n++) begin
                @(negedge g_clk);
                check_val({name, " busy"}, 1, s4_busy);
                check_val({name, " dmem_ack"}, 1, dmem_ack);
                @(posedge g_clk);
                #2;
            end
            dmem_recv  = 1'b1;                  // Response arrives
            dmem_error = resp_err;
            dmem_rdata = resp_data;
        end
        if (exp_redirect) begin
            wait_cf_req(name);
            check_redirect(name);
            if (exp_csr_chk)
                check_val({name, " csr en first"}, 1, csr.en);
            @(posedge g_clk);
            #2;
            dmem_recv = 1'b0;
            @(negedge g_clk);
            check_redirect({name, " held"});    // Request must stay put
            if (exp_csr_chk)
                check_val({name, " csr en held"}, 0, csr.en);
            @(posedge g_clk);
            #2;
            cf_ack = 1'b1;
        end
        wait_not_busy(name);
        if (!exp_redirect && resp_delay < 0)
            check_val({name, " stall cycles"}, 1, last_cycles);
        @(posedge g_clk);
        #2;
        s4_valid   = 1'b0;
        cf_ack     = 1'b0;
        dmem_recv  = 1'b0;
        dmem_error = 1'b0;
        @(negedge g_clk);
        check_idle(name);
        @(posedge g_clk);
        #2;
        finish_test(name, err_start);
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        lsu_size_t   sz;
        logic [1:0]  addr;
        fu_t         pick;
        s4_op_t      o;
        int          err_start;

        g_clk      = 1'b0;
        g_resetn   = 1'b0;
        errors     = 0;
        tests      = 0;
        lfsr       = 16'd63310;
        pc_model   = `WB_PC_RESET;
        s4_op      = '0;
        s4_valid   = 1'b0;
        csr_rdata  = '0;
        cf_ack     = 1'b0;
        dmem_recv  = 1'b0;
        dmem_error = 1'b0;
        dmem_rdata = '0;
        csr_mepc   = rand_bits(32) & 32'hFFFF_FFFC;
        csr_mtvec  = rand_bits(32) & 32'hFFFF_FFFC;
        clear_exp();

        // Reset held for 4 rising edges
        err_start = errors;
        @(negedge g_clk);
        check_idle("reset hold");
        repeat (3) @(posedge g_clk);
        #2;
        g_resetn = 1'b1;
        @(negedge g_clk);
        check_idle("reset release");
        @(posedge g_clk);
        #2;
        finish_test("reset_idle", err_start);

        // Finished results in opr_a, last one trap flagged
        for (int i = 0; i < 6; i++) begin
            pick = (i % 3 == 0) ? FU_ALU : (i % 3 == 1) ? FU_MUL : FU_ASI;
            a    = rand_bits(32);
            clear_exp();
            if (i < 5) begin
                exp_wen   = 1'b1;
                exp_wdata = a;
            end else begin
                exp_redirect = 1'b1;
                exp_target   = csr_mtvec;
                exp_trap     = 1'b1;
                exp_cause    = a[5:0];          // Cause from earlier stage
            end
            run_op($sformatf("pass_%0d", i), make_op(pick, 5'd0, a, rand_bits(32), i == 5));
        end

        // CSR access, even iterations always read, last one held by a trap
        for (int i = 0; i < 5; i++) begin
            a = rand_bits(32);
            b = rand_bits(32);
            r = rand_bits(4);
            r[3] = r[3] | (i % 2 == 0);
            clear_exp();
            csr_rdata     = rand_bits(32);
            exp_wen       = r[3] && (i < 4);
            exp_wdata     = csr_rdata;
            exp_fwd       = 2'b01;
            exp_csr_chk   = 1'b1;
            exp_csr.en    = (i < 4);            // Held op issued its access already
            exp_csr.wr    = r[2];
            exp_csr.set   = r[1];
            exp_csr.clr   = r[0];
            exp_csr.addr  = b[11:0];
            exp_csr.wdata = a;
            if (i == 4) begin
                exp_redirect = 1'b1;
                exp_target   = csr_mtvec;
                exp_trap     = 1'b1;
                exp_cause    = a[5:0];
            end
            run_op($sformatf("csr_%0d", i), make_op(FU_CSR, {1'b0, r[3:0]}, a, b, i == 4));
        end

        // Loads with a random response gap
        for (int i = 0; i < 6; i++) begin
            r    = rand_bits(5);
            sz   = (r[1:0] == 2'd1) ? LSU_BYTE : (r[1:0] == 2'd2) ? LSU_HALF : LSU_WORD;
            addr = r[4:3];
            if (sz == LSU_HALF)
                addr[0] = 1'b0;
            if (sz == LSU_WORD)
                addr = 2'b00;
            a      = rand_bits(32);
            a[0]   = (addr == 2'b00);           // Lane 0 strobe
            b      = rand_bits(32);
            b[1:0] = addr;
            clear_exp();
            resp_delay = rand_bits(2);
            resp_data  = rand_bits(32);
            exp_wen    = 1'b1;
            exp_wdata  = load_ref(resp_data, addr, sz, r[2]);
            exp_fwd    = 2'b10;
            o = make_op(FU_LSU, {1'b1, 1'b0, sz, r[2]}, a, b, 1'b0);
            run_op($sformatf("load_%0d", i), o);
        end

        // Control flow
        a = rand_bits(32) & 32'hFFFF_FFFC;
        o = make_op(FU_CFU, CFU_JALI, a, rand_bits(32), 1'b0);
        clear_exp();
        exp_redirect = 1'b1;
        exp_target   = a;
        exp_wen      = 1'b1;
        exp_wdata    = next_pc_ref(pc_model, o.size);   // Link address
        run_op("jali", o);

        a = rand_bits(32) & 32'hFFFF_FFFC;
        clear_exp();
        exp_redirect = 1'b1;
        exp_target   = a;
        run_op("branch_taken", make_op(FU_CFU, CFU_TAKEN, a, rand_bits(32), 1'b0));

        clear_exp();
        run_op("branch_not", make_op(FU_CFU, CFU_NOT_TAKEN, rand_bits(32), 0, 1'b0));

        clear_exp();
        exp_redirect = 1'b1;
        exp_target   = csr_mepc;
        exp_mret     = 1'b1;
        run_op("mret", make_op(FU_CFU, CFU_MRET, rand_bits(32), 0, 1'b0));

        // Traps to MTVEC
        clear_exp();
        exp_redirect = 1'b1;
        exp_target   = csr_mtvec;
        exp_trap     = 1'b1;
        exp_cause    = 6'd11;
        run_op("ecall", make_op(FU_CFU, CFU_ECALL, rand_bits(32), 0, 1'b0));

        exp_cause = 6'd3;
        run_op("ebreak", make_op(FU_CFU, CFU_EBREAK, rand_bits(32), 0, 1'b0));

        exp_cause  = 6'd5;
        exp_fwd    = 2'b10;
        resp_delay = 1;
        resp_err   = 1'b1;
        resp_data  = rand_bits(32);
        run_op("load_error", make_op(FU_LSU, {1'b1, 1'b0, LSU_WORD, 1'b0}, 1, 0, 1'b0));

        exp_cause = 6'd7;
        exp_fwd   = 2'b00;
        run_op("store_error", make_op(FU_LSU, {1'b0, 1'b1, LSU_WORD, 1'b0}, 0, 0, 1'b0));

        $display("tests %0d errors %0d", tests, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+verilog
verilog/wb_pkg.sv
verilog/wb_pc_track.sv
verilog/wb_csr_access.sv
verilog/wb_cfu.sv
verilog/wb_lsu_resp.sv
verilog/wb_load_align.sv
verilog/frv_writeback.sv
testbench/tb_writeback.sv

// ==== Bender.yml ====
package:
  name: frv_writeback

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/wb_pkg.sv
      - verilog/wb_pc_track.sv
      - verilog/wb_csr_access.sv
      - verilog/wb_cfu.sv
      - verilog/wb_lsu_resp.sv
      - verilog/wb_load_align.sv
      - verilog/frv_writeback.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/tb_writeback.sv
